// File: isaPkg.sv
// ISA package with instruction field widths, field types and opcode and funct encodings.
package isaPkg;

	localparam int InstrWidth  = 32;
	localparam int OpcodeWidth = 6;
	localparam int FunctWidth  = 6;
	localparam int RegIdxWidth = 5;
	localparam int ImmWidth    = 16;
	localparam int JumpWidth   = 26;

	typedef logic [InstrWidth-1:0]  instrWord;
	typedef logic [OpcodeWidth-1:0] opcodeT;
	typedef logic [FunctWidth-1:0]  functT;
	typedef logic [RegIdxWidth-1:0] regIdx;
	typedef logic [ImmWidth-1:0]    immField;
	typedef logic [JumpWidth-1:0]   jumpField;

	// major opcodes.
	localparam opcodeT opRType = 6'd0;
	localparam opcodeT opJ     = 6'd2;
	localparam opcodeT opJal   = 6'd3;
	localparam opcodeT opBeq   = 6'd4;
	localparam opcodeT opBne   = 6'd5;
	localparam opcodeT opAddi  = 6'd8;
	localparam opcodeT opAndi  = 6'd12;
	localparam opcodeT opOri   = 6'd13;
	localparam opcodeT opXori  = 6'd14;
	localparam opcodeT opLw    = 6'd35;
	localparam opcodeT opSw    = 6'd43;
	localparam opcodeT opHlt   = 6'd63;

	// funct codes under opRType.
	localparam functT fnSll = 6'd0;
	localparam functT fnSrl = 6'd2;
	localparam functT fnJr  = 6'd8;
	localparam functT fnAdd = 6'd32;
	localparam functT fnSub = 6'd34;
	localparam functT fnAnd = 6'd36;
	localparam functT fnOr  = 6'd37;
	localparam functT fnXor = 6'd38;
	localparam functT fnSlt = 6'd42;

endpackage

// File: corePkg.sv
// Core package with datapath word types, ALU operations, control bundle and run state.
package corePkg;

	import isaPkg::*;

	localparam int DataWidth     = 32;
	localparam int LoadAddrWidth = 16;

	typedef logic [DataWidth-1:0]     dataWord;
	typedef logic [LoadAddrWidth-1:0] loadAddr;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOpT;

	// one bundle per instruction, produced by the decoder.
	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrcImm;
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  isBranchEq;
		logic  isBranchNe;
		logic  isJump;
		logic  isJumpReg;
		logic  isLink;
		logic  isShift;
		logic  isHalt;
	} ctrlT;

	typedef enum logic [1:0] {
		stIdle,
		stRunning,
		stHalted
	} runStateT;

	// word index into instruction memory plus the word itself.
	typedef struct packed {
		loadAddr  addr;
		instrWord instr;
	} loadWord;

endpackage

// File: instrMemory.sv
// Instruction store with a synchronous load port and an asynchronous read at the PC.
module instrMemory
	import isaPkg::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     writeEn,
	input  logic [ImemAddrWidth-1:0] writeAddr,
	input  instrWord                 writeData,
	input  logic [ImemAddrWidth-1:0] readAddr,
	output instrWord                 instr
);

	localparam int Depth = 2 ** ImemAddrWidth;

	instrWord mem [Depth];

	// an all-zero word decodes as sll to r0, so unloaded slots act as no-ops.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEn) begin
			mem[writeAddr] <= writeData;
		end
	end

	assign instr = mem[readAddr];

endmodule

// File: instrDecoder.sv
// Instruction decoder producing the control bundle, register indices and immediate.
module instrDecoder
	import isaPkg::*;
	import corePkg::*;
(
	input  instrWord instr,
	output ctrlT     ctrl,
	output regIdx    rs,
	output regIdx    rt,
	output regIdx    dest,
	output dataWord  imm,
	output jumpField jumpTarget
);

	opcodeT     opcode;
	functT      funct;
	regIdx      rd;
	immField    immRaw;
	logic [4:0] shamt;
	logic       isLogicImm;

	assign opcode     = instr[31:26];
	assign rs         = instr[25:21];
	assign rt         = instr[20:16];
	assign rd         = instr[15:11];
	assign shamt      = instr[10:6];
	assign funct      = instr[5:0];
	assign immRaw     = instr[15:0];
	assign jumpTarget = instr[25:0];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnSub: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr:  ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSll: begin
						ctrl.aluOp = aluSll;
						ctrl.isShift = 1'b1;
					end
					fnSrl: begin
						ctrl.aluOp = aluSrl;
						ctrl.isShift = 1'b1;
					end
					fnJr: begin
						ctrl.regWrite = 1'b0;
						ctrl.isJumpReg = 1'b1;
					end
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opJ: ctrl.isJump = 1'b1;
			opJal: begin
				ctrl.isJump = 1'b1;
				ctrl.isLink = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluPassB;
			end
			opBeq: ctrl.isBranchEq = 1'b1;
			opBne: ctrl.isBranchNe = 1'b1;
			opAddi, opAndi, opOri, opXori: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				if (opcode == opAndi) ctrl.aluOp = aluAnd;
				else if (opcode == opOri) ctrl.aluOp = aluOr;
				else if (opcode == opXori) ctrl.aluOp = aluXor;
			end
			opLw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			opSw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opHlt: ctrl.isHalt = 1'b1;
			default: ;
		endcase
	end

	assign isLogicImm = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);

	always_comb begin
		if (ctrl.isShift) imm = {27'd0, shamt};
		else if (isLogicImm) imm = {16'd0, immRaw};
		else imm = {{16{immRaw[15]}}, immRaw};
	end

	// jal links into r31.
	always_comb begin
		if (ctrl.isLink) dest = 5'd31;
		else if (opcode == opRType) dest = rd;
		else dest = rt;
	end

endmodule

// File: regFile.sv
// Register file with 32 entries, two read ports, one write port and a debug read port.
module regFile
	import isaPkg::*;
	import corePkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    writeEn,
	input  regIdx   writeAddr,
	input  dataWord writeData,
	input  regIdx   readAddrA,
	input  regIdx   readAddrB,
	output dataWord readDataA,
	output dataWord readDataB,
	input  regIdx   dbgAddr,
	output dataWord dbgData
);

	localparam int NumRegs = 2 ** RegIdxWidth;

	dataWord regs [NumRegs];

	// r0 is never written, so it keeps its reset value of zero.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];
	assign dbgData   = regs[dbgAddr];

endmodule

// File: executeUnit.sv
// Execute stage with the ALU, the branch compare and next PC selection.
module executeUnit
	import isaPkg::*;
	import corePkg::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input  ctrlT                     ctrl,
	input  dataWord                  opA,
	input  dataWord                  opB,
	input  dataWord                  imm,
	input  jumpField                 jumpTarget,
	input  logic [ImemAddrWidth-1:0] pc,
	output dataWord                  aluResult,
	output logic [ImemAddrWidth-1:0] nextPc
);

	dataWord                  aluA;
	dataWord                  aluB;
	dataWord                  linkValue;
	logic [ImemAddrWidth-1:0] pcPlusOne;
	logic [ImemAddrWidth-1:0] branchTarget;
	logic                     branchTaken;

	assign pcPlusOne    = pc + 1'b1;
	assign branchTarget = pc + imm[ImemAddrWidth-1:0];
	assign linkValue    = dataWord'(pc) + dataWord'(1);

	// shifts take rt as the source and the shift amount as the distance.
	always_comb begin
		aluA = ctrl.isShift ? opB : opA;
		if (ctrl.isLink) aluB = linkValue;
		else if (ctrl.aluSrcImm || ctrl.isShift) aluB = imm;
		else aluB = opB;
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd:   aluResult = aluA + aluB;
			aluSub:   aluResult = aluA - aluB;
			aluAnd:   aluResult = aluA & aluB;
			aluOr:    aluResult = aluA | aluB;
			aluXor:   aluResult = aluA ^ aluB;
			aluSlt:   aluResult = ($signed(aluA) < $signed(aluB)) ? dataWord'(1) : '0;
			aluSll:   aluResult = aluA << aluB[4:0];
			aluSrl:   aluResult = aluA >> aluB[4:0];
			aluPassB: aluResult = aluB;
			default:  aluResult = '0;
		endcase
	end

	assign branchTaken = (ctrl.isBranchEq && (opA == opB)) ||
		(ctrl.isBranchNe && (opA != opB));

	// branch offsets are relative to the branch itself, not pc plus one.
	always_comb begin
		if (ctrl.isJump) nextPc = jumpTarget[ImemAddrWidth-1:0];
		else if (ctrl.isJumpReg) nextPc = opA[ImemAddrWidth-1:0];
		else if (branchTaken) nextPc = branchTarget;
		else nextPc = pcPlusOne;
	end

endmodule

// File: resultUnit.sv
// Result stage with the data memory and the write-back value selection.
module resultUnit
	import corePkg::*;
#(
	parameter int DmemAddrWidth = 8
) (
	input  logic    clk,
	input  logic    rst,
	input  ctrlT    ctrl,
	input  logic    enable,
	input  dataWord aluResult,
	input  dataWord storeData,
	output dataWord writeData,
	output logic    writeEn
);

	localparam int Depth = 2 ** DmemAddrWidth;

	dataWord                  mem [Depth];
	logic [DmemAddrWidth-1:0] addr;
	dataWord                  readWord;

	// word addressed by the low bits of the ALU result.
	assign addr = aluResult[DmemAddrWidth-1:0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else if (ctrl.memWrite && enable) begin
			mem[addr] <= storeData;
		end
	end

	assign readWord  = ctrl.memRead ? mem[addr] : '0;
	assign writeData = ctrl.memToReg ? readWord : aluResult;
	assign writeEn   = ctrl.regWrite && enable;

endmodule

// File: processorCore.sv
// Single-cycle core top with PC, run control, cycle counter and program load port.
module processorCore
	import isaPkg::*;
	import corePkg::*;
#(
	parameter int ImemAddrWidth = 8,
	parameter int DmemAddrWidth = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic                     loadValid,
	output logic                     loadReady,
	input  loadWord                  loadData,
	output logic                     halted,
	output dataWord                  cycles,
	output logic [ImemAddrWidth-1:0] pc,
	input  regIdx                    dbgAddr,
	output dataWord                  dbgData
);

	runStateT                 runState;
	logic                     running;
	logic                     loadFire;
	logic                     startFire;
	instrWord                 instr;
	ctrlT                     ctrl;
	regIdx                    rs;
	regIdx                    rt;
	regIdx                    dest;
	dataWord                  imm;
	jumpField                 jumpTarget;
	dataWord                  rsData;
	dataWord                  rtData;
	dataWord                  aluResult;
	logic [ImemAddrWidth-1:0] nextPc;
	dataWord                  wbData;
	logic                     wbEn;

	assign running   = (runState == stRunning);
	// idle reads as halted too since nothing is executing.
	assign halted    = !running;
	assign loadReady = !running;
	assign loadFire  = loadValid && loadReady;
	assign startFire = start && !running && !loadFire;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			runState <= stIdle;
			pc <= '0;
			cycles <= '0;
		end else if (running) begin
			cycles <= cycles + dataWord'(1);
			// pc stays on the hlt instruction.
			if (ctrl.isHalt) runState <= stHalted;
			else pc <= nextPc;
		end else if (startFire) begin
			runState <= stRunning;
			pc <= '0;
			cycles <= '0;
		end
	end

	instrMemory #(.ImemAddrWidth(ImemAddrWidth)) imem (
		.clk(clk), .rst(rst),
		.writeEn(loadFire), .writeAddr(loadData.addr[ImemAddrWidth-1:0]),
		.writeData(loadData.instr),
		.readAddr(pc), .instr(instr)
	);

	instrDecoder decoder (
		.instr(instr), .ctrl(ctrl), .rs(rs), .rt(rt), .dest(dest),
		.imm(imm), .jumpTarget(jumpTarget)
	);

	regFile regs (
		.clk(clk), .rst(rst),
		.writeEn(wbEn), .writeAddr(dest), .writeData(wbData),
		.readAddrA(rs), .readAddrB(rt), .readDataA(rsData), .readDataB(rtData),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	executeUnit #(.ImemAddrWidth(ImemAddrWidth)) execute (
		.ctrl(ctrl), .opA(rsData), .opB(rtData), .imm(imm),
		.jumpTarget(jumpTarget), .pc(pc),
		.aluResult(aluResult), .nextPc(nextPc)
	);

	// enable keeps the datapath from writing anything outside a run.
	resultUnit #(.DmemAddrWidth(DmemAddrWidth)) result (
		.clk(clk), .rst(rst), .ctrl(ctrl), .enable(running),
		.aluResult(aluResult), .storeData(rtData),
		.writeData(wbData), .writeEn(wbEn)
	);

endmodule

// File: processorCore_checker.sv
// Bound checker for the load handshake and halt behavior of the processor core.
module processorCoreChecker
	import corePkg::*;
#(
	parameter int ImemAddrWidth = 8
) (
	input logic                     clk,
	input logic                     rst,
	input runStateT                 runState,
	input logic                     loadReady,
	input logic                     halted,
	input logic                     startFire,
	input ctrlT                     ctrl,
	input dataWord                  cycles,
	input logic [ImemAddrWidth-1:0] pc
);

	timeunit 1ns;
	timeprecision 1ps;

	readyLowWhileRunning: assert property (@(posedge clk) disable iff (!rst)
		(runState == stRunning) |-> !loadReady)
		else $error("loadReady is high while the core is running");

	// only a start may move pc or cycles out of the halted state.
	haltedHoldsState: assert property (@(posedge clk) disable iff (!rst)
		(runState == stHalted && !startFire) |=> ($stable(pc) && $stable(cycles)))
		else $error("pc or cycles changed while halted");

	haltOnlyOnHlt: assert property (@(posedge clk) disable iff (!rst)
		$rose(halted) |-> $past(runState == stRunning && ctrl.isHalt))
		else $error("halted rose without a retired hlt");

endmodule

bind processorCore processorCoreChecker #(.ImemAddrWidth(ImemAddrWidth)) coreChecker (
	.clk(clk), .rst(rst), .runState(runState), .loadReady(loadReady),
	.halted(halted), .startFire(startFire), .ctrl(ctrl), .cycles(cycles), .pc(pc)
);

// File: processorTb.sv
// Directed testbench for the single-cycle processor core.
module processorTb
	import isaPkg::*;
	import corePkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ImemAddrWidth  = 8;
	localparam int DmemAddrWidth  = 8;
	localparam int ClkPeriod      = 100;
	localparam int NumTests       = 7;
	localparam int RunLimit       = 500;
	localparam int WatchdogCycles = NumTests * 200 + 200;

	logic                     clk;
	logic                     rst;
	logic                     start;
	logic                     loadValid;
	logic                     loadReady;
	loadWord                  loadData;
	logic                     halted;
	dataWord                  cycles;
	logic [ImemAddrWidth-1:0] pc;
	regIdx                    dbgAddr;
	dataWord                  dbgData;

	instrWord prog [$];
	int       seed = 32'hfceb;
	int       errorCount = 0;
	int       checkCount = 0;

	processorCore #(.ImemAddrWidth(ImemAddrWidth), .DmemAddrWidth(DmemAddrWidth))
	processorCore_inst (
		.clk(clk), .rst(rst), .start(start),
		.loadValid(loadValid), .loadReady(loadReady), .loadData(loadData),
		.halted(halted), .cycles(cycles), .pc(pc),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	function automatic instrWord encodeR(functT funct, regIdx rd, regIdx rs, regIdx rt,
		logic [4:0] shamt);
		return {opRType, rs, rt, rd, shamt, funct};
	endfunction

	function automatic instrWord encodeI(opcodeT op, regIdx rt, regIdx rs, immField imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instrWord encodeJ(opcodeT op, jumpField target);
		return {op, target};
	endfunction

	function automatic dataWord signExtend(immField imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic emit(input instrWord word);
		prog.push_back(word);
	endtask

	// no lui in this ISA, so a full word is built from two halves.
	task automatic emitConst(input regIdx r, input dataWord value);
		emit(encodeI(opAddi, r, 5'd0, value[31:16]));
		emit(encodeR(fnSll, r, 5'd0, r, 5'd16));
		emit(encodeI(opOri, r, r, value[15:0]));
	endtask

	task automatic emitHalt();
		emit({opHlt, 26'd0});
	endtask

	task automatic loadProgram();
		@(posedge clk);
		for (int i = 0; i < prog.size(); i++) begin
			loadValid <= 1'b1;
			loadData <= {loadAddr'(i), prog[i]};
			@(negedge clk);
			while (!loadReady) begin
				@(negedge clk);
			end
			@(posedge clk);
		end
		loadValid <= 1'b0;
		prog.delete();
	endtask

	task automatic startRun();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic waitHalt();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!halted && waited < RunLimit) begin
			@(negedge clk);
			waited++;
		end
		if (!halted) begin
			$display("run did not reach halt within %0d cycles", RunLimit);
			errorCount++;
		end
	endtask

	task automatic runProgram();
		startRun();
		waitHalt();
	endtask

	task automatic checkValue(input string what, input dataWord actual, input dataWord expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic checkReg(input regIdx idx, input dataWord expected);
		@(posedge clk);
		dbgAddr <= idx;
		@(negedge clk);
		checkValue($sformatf("r%0d", idx), dbgData, expected);
	endtask

	task automatic resetTest();
		@(negedge clk);
		checkValue("halted after reset", dataWord'(halted), 32'd1);
		checkValue("loadReady after reset", dataWord'(loadReady), 32'd1);
		checkValue("cycles after reset", cycles, 32'd0);
		checkValue("pc after reset", dataWord'(pc), 32'd0);
	endtask

	task automatic aluTest();
		dataWord a;
		dataWord b;
		a = $random(seed);
		b = $random(seed);
		emitConst(5'd1, a);
		emitConst(5'd2, b);
		emit(encodeR(fnAdd, 5'd3, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnSub, 5'd4, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnAnd, 5'd5, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnOr, 5'd10, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnXor, 5'd11, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnSlt, 5'd12, 5'd1, 5'd2, 5'd0));
		emit(encodeR(fnSlt, 5'd13, 5'd2, 5'd1, 5'd0));
		emitHalt();
		loadProgram();
		runProgram();
		checkReg(5'd1, a);
		checkReg(5'd2, b);
		checkReg(5'd3, a + b);
		checkReg(5'd4, a - b);
		checkReg(5'd5, a & b);
		checkReg(5'd10, a | b);
		checkReg(5'd11, a ^ b);
		checkReg(5'd12, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		checkReg(5'd13, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
	endtask

	task automatic immediateTest();
		dataWord    a;
		dataWord    rnd;
		immField    negImm;
		logic [4:0] shiftL;
		logic [4:0] shiftR;
		a = $random(seed);
		rnd = $random(seed);
		negImm = rnd[15:0] | 16'h8000;
		shiftL = rnd[20:16];
		shiftR = rnd[28:24];
		emitConst(5'd1, a);
		emit(encodeI(opAndi, 5'd2, 5'd1, negImm));
		emit(encodeI(opOri, 5'd3, 5'd1, negImm));
		emit(encodeI(opXori, 5'd4, 5'd1, negImm));
		emit(encodeI(opAddi, 5'd5, 5'd1, negImm));
		emit(encodeR(fnSll, 5'd10, 5'd0, 5'd1, shiftL));
		emit(encodeR(fnSrl, 5'd11, 5'd0, 5'd1, shiftR));
		emit(encodeI(opAddi, 5'd0, 5'd1, 16'd123));
		emitHalt();
		loadProgram();
		runProgram();
		checkReg(5'd2, a & {16'h0000, negImm});
		checkReg(5'd3, a | {16'h0000, negImm});
		checkReg(5'd4, a ^ {16'h0000, negImm});
		checkReg(5'd5, a + signExtend(negImm));
		checkReg(5'd10, a << shiftL);
		checkReg(5'd11, a >> shiftR);
		checkReg(5'd0, 32'd0);
	endtask

	task automatic memoryTest();
		dataWord values [4];
		for (int i = 0; i < 4; i++) begin
			values[i] = $random(seed);
			emitConst(regIdx'(i + 1), values[i]);
		end
		emit(encodeI(opAddi, 5'd5, 5'd0, 16'd20));
		emit(encodeI(opSw, 5'd1, 5'd0, 16'd10));
		emit(encodeI(opSw, 5'd2, 5'd0, 16'd11));
		emit(encodeI(opSw, 5'd3, 5'd0, 16'd12));
		// base plus offset lands on word 23.
		emit(encodeI(opSw, 5'd4, 5'd5, 16'd3));
		emit(encodeI(opLw, 5'd10, 5'd0, 16'd10));
		emit(encodeI(opLw, 5'd11, 5'd0, 16'd11));
		emit(encodeI(opLw, 5'd12, 5'd0, 16'd12));
		emit(encodeI(opLw, 5'd13, 5'd0, 16'd23));
		emitHalt();
		loadProgram();
		runProgram();
		checkReg(5'd10, values[0]);
		checkReg(5'd11, values[1]);
		checkReg(5'd12, values[2]);
		checkReg(5'd13, values[3]);
	endtask

	// branch offsets count from the branch itself.
	task automatic controlFlowTest();
		emit(encodeI(opAddi, 5'd20, 5'd0, 16'd0));
		emit(encodeI(opAddi, 5'd21, 5'd0, 16'd5));
		emit(encodeI(opAddi, 5'd22, 5'd0, 16'd5));
		emit(encodeI(opBeq, 5'd22, 5'd21, 16'd2));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd100));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd1));
		emit(encodeI(opBne, 5'd22, 5'd21, 16'd2));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd2));
		emit(encodeI(opBne, 5'd0, 5'd21, 16'd2));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd100));
		emit(encodeI(opBeq, 5'd0, 5'd21, 16'd2));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd4));
		// 12 jumps over 13.
		emit(encodeJ(opJ, 26'd14));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd100));
		emit(encodeJ(opJal, 26'd18));
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd8));
		emitHalt();
		emit(encodeI(opAddi, 5'd20, 5'd20, 16'd100));
		// subroutine at 18 copies the link and returns.
		emit(encodeI(opAddi, 5'd23, 5'd31, 16'd0));
		emit(encodeR(fnJr, 5'd0, 5'd31, 5'd0, 5'd0));
		loadProgram();
		runProgram();
		checkReg(5'd20, 32'd15);
		checkReg(5'd31, 32'd15);
		checkReg(5'd23, 32'd15);
		checkValue("pc", dataWord'(pc), 32'd16);
	endtask

	task automatic haltTest();
		for (int i = 0; i < 5; i++) begin
			emit(encodeI(opAddi, 5'd8, 5'd8, 16'd1));
		end
		emitHalt();
		loadProgram();
		runProgram();
		checkValue("cycles", cycles, 32'd6);
		checkValue("pc", dataWord'(pc), 32'd5);
		repeat (3) begin
			@(negedge clk);
			checkValue("halted", dataWord'(halted), 32'd1);
			checkValue("held pc", dataWord'(pc), 32'd5);
			checkValue("held cycles", cycles, 32'd6);
		end
		for (int i = 0; i < 3; i++) begin
			emit(encodeI(opAddi, 5'd9, 5'd0, 16'(i)));
		end
		emitHalt();
		loadProgram();
		runProgram();
		checkValue("cycles after restart", cycles, 32'd4);
		checkValue("pc after restart", dataWord'(pc), 32'd3);
	endtask

	task automatic loadHandshakeTest();
		int waited;
		int accepted;
		emit(encodeI(opAddi, 5'd6, 5'd0, 16'd1));
		emit(encodeI(opAddi, 5'd7, 5'd0, 16'd0));
		for (int i = 0; i < 7; i++) begin
			emit(encodeI(opAddi, 5'd7, 5'd7, 16'd1));
		end
		emitHalt();
		loadProgram();
		startRun();
		// the held word replaces the first instruction once the run is over.
		@(posedge clk);
		loadValid <= 1'b1;
		loadData <= {loadAddr'(0), encodeI(opAddi, 5'd6, 5'd0, 16'd99)};
		waited = 0;
		accepted = 0;
		@(negedge clk);
		while (!halted && waited < RunLimit) begin
			if (loadReady) begin
				errorCount++;
				$display("ERROR at %0d ns: loadReady high during a run", $time);
			end
			@(negedge clk);
			waited++;
		end
		while (loadValid && waited < RunLimit) begin
			if (loadReady) accepted++;
			@(posedge clk);
			if (accepted > 0) loadValid <= 1'b0;
			@(negedge clk);
			waited++;
		end
		checkValue("accepted words", dataWord'(accepted), 32'd1);
		checkReg(5'd6, 32'd1);
		checkReg(5'd7, 32'd7);
		runProgram();
		checkReg(5'd6, 32'd99);
		checkReg(5'd7, 32'd7);
	endtask

	initial begin
		rst = 1'b0;
		start = 1'b0;
		loadValid = 1'b0;
		loadData = '0;
		dbgAddr = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		resetTest();
		aluTest();
		immediateTest();
		memoryTest();
		controlFlowTest();
		haltTest();
		loadHandshakeTest();
		$display("errors: %0d in %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: project.f
isaPkg.sv
corePkg.sv
instrMemory.sv
instrDecoder.sv
regFile.sv
executeUnit.sv
resultUnit.sv
processorCore.sv
processorCore_checker.sv
processorTb.sv
